// ==== hw/des_types_pkg.sv ====
package des_types_pkg;

    // full DES runs sixteen rounds; fewer are only for reduced-round testing.
    localparam int DES_ROUNDS = 16;

    // a 64-bit data or key block, bit 63 being DES bit 1.
    typedef logic [63:0] block_t;

    // one Feistel half, L or R.
    typedef logic [31:0] half_t;

    // one key-schedule half, C or D.
    typedef logic [27:0] cd_t;

    // round subkey after PC-2.
    typedef logic [47:0] subkey_t;

    // round index, counted from 1.
    typedef logic [4:0] round_t;

    typedef enum logic
    {
        IDLE = 1'b0,
        RUN  = 1'b1
    } ctrl_state_t;

endpackage

// ==== hw/des_tables_pkg.sv ====
package des_tables_pkg;

    // entries use the DES numbering, where bit 1 is the most significant input bit.
    // tables shorter than 64 entries are padded with zeros that are never read.
    typedef logic [6:0] perm_tbl_t [64];

    localparam perm_tbl_t ip_perm = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    localparam perm_tbl_t fp_perm = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    localparam perm_tbl_t pc1_perm = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18, 10,  2,
        59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36, 63, 55, 47, 39,
        31, 23, 15,  7, 62, 54, 46, 38, 30, 22, 14,  6, 61, 53, 45, 37,
        29, 21, 13,  5, 28, 20, 12,  4,  0,  0,  0,  0,  0,  0,  0,  0
    };

    localparam perm_tbl_t pc2_perm = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
        26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32,
         0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0
    };

    localparam perm_tbl_t e_perm = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1,
         0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0
    };

    localparam perm_tbl_t p_perm = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25,
         0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,
         0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0
    };

    // rotation amount per key-schedule step, step 1 first.
    localparam logic [1:0] shift_sched [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // each box is indexed by {outer bits, middle four bits}, so row-major order.
    localparam logic [3:0] sbox_lut [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

    // takes an in_w-bit value right-justified in din, returns out_w bits right-justified.
    function automatic des_types_pkg::block_t permute(des_types_pkg::block_t din, int in_w,
                                                      perm_tbl_t tbl, int out_w);
        des_types_pkg::block_t dout;
        dout = '0;
        for (int i = 0; i < out_w; i++)
        begin
            dout[out_w - 1 - i] = din[in_w - int'(tbl[i])];
        end
        return dout;
    endfunction

    function automatic logic [3:0] sbox_lookup(int n, logic [5:0] din);
        return sbox_lut[n][{din[5], din[0], din[4:1]}];
    endfunction

    function automatic des_types_pkg::half_t feistel_f(des_types_pkg::half_t r,
                                                       des_types_pkg::subkey_t k);
        des_types_pkg::block_t expanded;
        des_types_pkg::subkey_t mixed;
        des_types_pkg::half_t s_out;
        des_types_pkg::block_t p_out;
        expanded = permute({32'b0, r}, 32, e_perm, 48);
        mixed = expanded[47:0] ^ k;
        for (int i = 0; i < 8; i++)
        begin
            s_out[31 - 4 * i -: 4] = sbox_lookup(i, mixed[47 - 6 * i -: 6]);
        end
        p_out = permute({32'b0, s_out}, 32, p_perm, 32);
        return p_out[31:0];
    endfunction

endpackage

// ==== hw/des_round_ctrl.sv ====
module des_round_ctrl #(
    parameter int NUM_ROUNDS = des_types_pkg::DES_ROUNDS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic                  load,
    output logic                  round_en,
    output des_types_pkg::round_t round_idx,
    output logic                  done
);

    des_types_pkg::ctrl_state_t state;

    // load must act on the same edge that samples start, so it is decoded.
    assign load = (state == des_types_pkg::IDLE) && start;
    assign round_en = (state == des_types_pkg::RUN);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= des_types_pkg::IDLE;
            round_idx <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                des_types_pkg::IDLE:
                begin
                    if (start)
                    begin
                        state <= des_types_pkg::RUN;
                        round_idx <= des_types_pkg::round_t'(1);
                    end
                end
                des_types_pkg::RUN:
                begin
                    // the last round is applied on this edge, so done shows next cycle.
                    if (round_idx == des_types_pkg::round_t'(NUM_ROUNDS))
                    begin
                        state <= des_types_pkg::IDLE;
                        done <= 1'b1;
                    end
                    else
                    begin
                        round_idx <= round_idx + des_types_pkg::round_t'(1);
                    end
                end
                default:
                begin
                    state <= des_types_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/des_key_schedule.sv ====
module des_key_schedule (
    input  logic                   clk,
    input  des_types_pkg::block_t  key,
    input  logic                   load,
    input  logic                   round_en,
    input  des_types_pkg::round_t  round_idx,
    output des_types_pkg::subkey_t subkey
);

    des_types_pkg::cd_t c_reg;
    des_types_pkg::cd_t d_reg;
    des_types_pkg::block_t pc1_out;
    des_types_pkg::block_t pc2_out;
    logic [3:0] sched_idx;
    logic [1:0] shift;

    assign pc1_out = des_tables_pkg::permute(key, 64, des_tables_pkg::pc1_perm, 56);

    // round r rotates by step 17 - r, which walks the encryption schedule backwards.
    assign sched_idx = 4'(5'd16 - round_idx);
    assign shift = des_tables_pkg::shift_sched[sched_idx];

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            c_reg <= pc1_out[55:28];
            d_reg <= pc1_out[27:0];
        end
        else if (round_en)
        begin
            if (shift == 2'd2)
            begin
                c_reg <= {c_reg[1:0], c_reg[27:2]};
                d_reg <= {d_reg[1:0], d_reg[27:2]};
            end
            else
            begin
                c_reg <= {c_reg[0], c_reg[27:1]};
                d_reg <= {d_reg[0], d_reg[27:1]};
            end
        end
    end

    // the loaded halves already give K16 since a full schedule rotates by 28.
    assign pc2_out = des_tables_pkg::permute({8'b0, c_reg, d_reg}, 56,
                                             des_tables_pkg::pc2_perm, 48);
    assign subkey = pc2_out[47:0];

endmodule

// ==== hw/des_round_datapath.sv ====
module des_round_datapath (
    input  logic                   clk,
    input  des_types_pkg::block_t  cipher,
    input  logic                   load,
    input  logic                   round_en,
    input  des_types_pkg::subkey_t subkey,
    output des_types_pkg::block_t  plain
);

    des_types_pkg::half_t l_reg;
    des_types_pkg::half_t r_reg;
    des_types_pkg::half_t f_out;
    des_types_pkg::block_t ip_out;

    assign ip_out = des_tables_pkg::permute(cipher, 64, des_tables_pkg::ip_perm, 64);
    assign f_out = des_tables_pkg::feistel_f(r_reg, subkey);

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            l_reg <= ip_out[63:32];
            r_reg <= ip_out[31:0];
        end
        else if (round_en)
        begin
            l_reg <= r_reg;
            r_reg <= l_reg ^ f_out;
        end
    end

    // the halves are swapped back before FP, undoing the last round's exchange.
    assign plain = des_tables_pkg::permute({r_reg, l_reg}, 64, des_tables_pkg::fp_perm, 64);

endmodule

// ==== hw/des_decrypt_core.sv ====
module des_decrypt_core #(
    parameter int NUM_ROUNDS = des_types_pkg::DES_ROUNDS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  des_types_pkg::block_t key,
    input  des_types_pkg::block_t cipher,
    output des_types_pkg::block_t plain,
    output logic                  done
);

    logic load;
    logic round_en;
    des_types_pkg::round_t round_idx;
    des_types_pkg::subkey_t subkey;

    des_round_ctrl #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .load      (load),
        .round_en  (round_en),
        .round_idx (round_idx),
        .done      (done)
    );

    des_key_schedule keys0 (
        .clk       (clk),
        .key       (key),
        .load      (load),
        .round_en  (round_en),
        .round_idx (round_idx),
        .subkey    (subkey)
    );

    // one round per clock, keyed by the subkey of the current schedule step.
    des_round_datapath data0 (
        .clk      (clk),
        .cipher   (cipher),
        .load     (load),
        .round_en (round_en),
        .subkey   (subkey),
        .plain    (plain)
    );

endmodule

// ==== tb/des_model.svh ====
function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// subkey n of the encryption schedule, found by rotating left n schedule steps.
function automatic des_types_pkg::subkey_t forward_subkey(des_types_pkg::block_t k, int n);
    des_types_pkg::block_t pc1;
    des_types_pkg::block_t pc2;
    des_types_pkg::cd_t c;
    des_types_pkg::cd_t d;
    pc1 = des_tables_pkg::permute(k, 64, des_tables_pkg::pc1_perm, 56);
    c = pc1[55:28];
    d = pc1[27:0];
    for (int i = 0; i < n; i++)
    begin
        for (int s = 0; s < int'(des_tables_pkg::shift_sched[i]); s++)
        begin
            c = {c[26:0], c[27]};
            d = {d[26:0], d[27]};
        end
    end
    pc2 = des_tables_pkg::permute({8'b0, c, d}, 56, des_tables_pkg::pc2_perm, 48);
    return pc2[47:0];
endfunction

function automatic des_types_pkg::block_t des_crypt(des_types_pkg::block_t blk,
                                                    des_types_pkg::block_t k, bit decrypt);
    des_types_pkg::block_t ip;
    des_types_pkg::half_t l;
    des_types_pkg::half_t r;
    des_types_pkg::half_t t;
    des_types_pkg::subkey_t sk;
    ip = des_tables_pkg::permute(blk, 64, des_tables_pkg::ip_perm, 64);
    l = ip[63:32];
    r = ip[31:0];
    for (int i = 1; i <= 16; i++)
    begin
        sk = decrypt ? forward_subkey(k, 17 - i) : forward_subkey(k, i);
        t = r;
        r = l ^ des_tables_pkg::feistel_f(r, sk);
        l = t;
    end
    return des_tables_pkg::permute({r, l}, 64, des_tables_pkg::fp_perm, 64);
endfunction

function automatic des_types_pkg::block_t des_encrypt(des_types_pkg::block_t pt,
                                                      des_types_pkg::block_t k);
    return des_crypt(pt, k, 1'b0);
endfunction

function automatic des_types_pkg::block_t des_decrypt(des_types_pkg::block_t ct,
                                                      des_types_pkg::block_t k);
    return des_crypt(ct, k, 1'b1);
endfunction

// ==== tb/des_decrypt_tb.sv ====
module des_decrypt_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DONE_TIMEOUT = 40;
    localparam int RANDOM_RUNS = 200;

    logic clk;
    logic reset;
    logic start;
    des_types_pkg::block_t key;
    des_types_pkg::block_t cipher;
    des_types_pkg::block_t plain;
    logic done;

    logic [31:0] rng_state;
    int checks;
    int errors;

    `include "des_model.svh"

    des_decrypt_core dut0 (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .key    (key),
        .cipher (cipher),
        .plain  (plain),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic draw_block(output des_types_pkg::block_t value);
        rng_state = xorshift32(rng_state);
        value[63:32] = rng_state;
        rng_state = xorshift32(rng_state);
        value[31:0] = rng_state;
    endtask

    task automatic check_block(input string what, input des_types_pkg::block_t got,
                               input des_types_pkg::block_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input string what, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // latency counts falling edges after the start edge, so done shows at 16.
    task automatic run_block(input des_types_pkg::block_t k, input des_types_pkg::block_t c,
                             output des_types_pkg::block_t result, output int latency);
        @(negedge clk);
        key = k;
        cipher = c;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        latency = 0;
        while (!done && latency < DONE_TIMEOUT)
        begin
            @(negedge clk);
            latency++;
        end
        checks++;
        assert (done)
        else
        begin
            errors++;
            $display("timeout: done never arrived within %0d cycles", DONE_TIMEOUT);
        end
        result = plain;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    initial
    begin
        des_types_pkg::block_t k_a;
        des_types_pkg::block_t p_a;
        des_types_pkg::block_t c_a;
        des_types_pkg::block_t k_b;
        des_types_pkg::block_t c_b;
        des_types_pkg::block_t result;
        des_types_pkg::block_t held;
        int latency;
        int cycles;
        int done_count;
        int errors_before;

        reset = 1'b1;
        start = 1'b0;
        key = '0;
        cipher = '0;
        rng_state = 32'h23f3c08b;
        checks = 0;
        errors = 0;

        repeat (4) @(negedge clk);
        reset = 1'b0;

        errors_before = errors;
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            checks++;
            assert (done === 1'b0)
            else
            begin
                errors++;
                $display("mismatch at %0d ns: done is high while the core is idle after reset",
                         $time);
            end
        end
        report_test("reset state", errors_before);

        errors_before = errors;
        check_block("model encryption of known answer",
                    des_encrypt(64'h0123456789abcdef, 64'h133457799bbcdff1),
                    64'h85e813540f0ab405);
        run_block(64'h133457799bbcdff1, 64'h85e813540f0ab405, result, latency);
        check_block("known answer plain", result, 64'h0123456789abcdef);
        report_test("known answer", errors_before);

        errors_before = errors;
        check_int("done latency", latency, 16);
        @(negedge clk);
        check_int("done one cycle later", int'(done), 0);
        report_test("latency", errors_before);

        errors_before = errors;
        for (int i = 0; i < RANDOM_RUNS; i++)
        begin
            draw_block(k_a);
            draw_block(p_a);
            c_a = des_encrypt(p_a, k_a);
            run_block(k_a, c_a, result, latency);
            check_block("round trip plain", result, p_a);
            check_block("plain against model decryption", result, des_decrypt(c_a, k_a));
        end
        report_test("random round trip", errors_before);

        errors_before = errors;
        draw_block(k_a);
        draw_block(p_a);
        c_a = des_encrypt(p_a, k_a);
        draw_block(k_b);
        draw_block(c_b);
        @(negedge clk);
        key = k_a;
        cipher = c_a;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        done_count = 0;
        result = '0;
        while (cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            if (done)
            begin
                done_count++;
                if (done_count == 1)
                    result = plain;
            end
            // a second block arrives five cycles into the run.
            if (cycles == 5)
            begin
                key = k_b;
                cipher = c_b;
                start = 1'b1;
            end
            else
            begin
                start = 1'b0;
            end
        end
        check_int("done pulses in window", done_count, 1);
        check_block("plain with start while busy", result, p_a);
        report_test("start while busy", errors_before);

        errors_before = errors;
        draw_block(k_a);
        draw_block(p_a);
        c_a = des_encrypt(p_a, k_a);
        run_block(k_a, c_a, held, latency);
        check_block("plain before hold", held, p_a);
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            draw_block(key);
            draw_block(cipher);
            check_block("held plain", plain, held);
        end
        report_test("result hold", errors_before);

        $display("summary: %0d checks run, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tb
hw/des_types_pkg.sv
hw/des_tables_pkg.sv
hw/des_round_ctrl.sv
hw/des_key_schedule.sv
hw/des_round_datapath.sv
hw/des_decrypt_core.sv
tb/des_decrypt_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f verilog.f --top-module des_decrypt_tb -Mdir obj_dir -o des_decrypt_sim \
    > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $build_log"
    exit 1
fi

./obj_dir/des_decrypt_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$sim_log"; then
    exit 1
fi
exit 0
